//--- verilog/cnn_pkg.sv
package cnn_pkg;

    // fixed-point word, 2 fraction bits
    localparam int WORD_W = 16;
    localparam int FRAC_W = 2;
    localparam int PROD_W = 2 * WORD_W;

    typedef logic signed [WORD_W-1:0] word_t;

    // layer dimensions
    localparam int IN_ROWS    = 5;
    localparam int IN_COLS    = 2;
    localparam int K_ROWS     = 3;
    localparam int N_CONV     = IN_ROWS - K_ROWS + 1;
    localparam int N_HIDDEN   = 2;
    localparam int N_OUT      = 4;
    localparam int FIFO_DEPTH = 4;

    // counter and pointer widths
    localparam int ROW_W      = $clog2(IN_ROWS);
    localparam int TAP_ROW_W  = $clog2(K_ROWS);
    localparam int TAP_COL_W  = $clog2(IN_COLS);
    localparam int CONV_IDX_W = $clog2(N_CONV);
    localparam int HID_IDX_W  = $clog2(N_HIDDEN);
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

    // conv layer FSM encoding
    localparam logic [1:0] CONV_ST_IDLE = 2'd0;
    localparam logic [1:0] CONV_ST_MAC  = 2'd1;
    localparam logic [1:0] CONV_ST_BIAS = 2'd2;
    localparam logic [1:0] CONV_ST_SEND = 2'd3;

    // fc stack FSM encoding
    localparam logic [2:0] FC_ST_ACC   = 3'd0;
    localparam logic [2:0] FC_ST_HBIAS = 3'd1;
    localparam logic [2:0] FC_ST_OUT   = 3'd2;
    localparam logic [2:0] FC_ST_OBIAS = 3'd3;
    localparam logic [2:0] FC_ST_HOLD  = 3'd4;

    // kernel [row][col], values in quarters
    // 1 -1.5 / 2 -2 / -1.5 1
    localparam word_t KERNEL [K_ROWS][IN_COLS] = '{
        '{16'sd4, -16'sd6},
        '{16'sd8, -16'sd8},
        '{-16'sd6, 16'sd4}
    };

    // 3.75
    localparam word_t CONV_BIAS = 16'sd15;

    // hidden weights [neuron][conv output]
    // neuron 0: 2 -0.5 -0.5, neuron 1: -0.5 1.5 1
    localparam word_t HID_W [N_HIDDEN][N_CONV] = '{
        '{16'sd8, -16'sd2, -16'sd2},
        '{-16'sd2, 16'sd6, 16'sd4}
    };

    // -0.5 per hidden neuron
    localparam word_t HID_BIAS [N_HIDDEN] = '{-16'sd2, -16'sd2};

    // output weights [neuron][hidden word]
    localparam word_t OUT_W [N_OUT][N_HIDDEN] = '{
        '{16'sd0, 16'sd2},
        '{-16'sd4, -16'sd4},
        '{16'sd4, 16'sd4},
        '{16'sd4, 16'sd8}
    };

    // 0.5 per output neuron
    localparam word_t OUT_BIAS [N_OUT] = '{16'sd2, 16'sd2, 16'sd2, 16'sd2};

    // full product, floor shift by the fraction width, then keep the low word
    function automatic word_t fx_mul(input word_t a, input word_t b);
        logic signed [PROD_W-1:0] prod;
        prod = PROD_W'(a) * PROD_W'(b);
        return WORD_W'(prod >>> FRAC_W);
    endfunction

endpackage

//--- verilog/feature_stream_if.sv
`timescale 1ns/1ps

interface feature_stream_if import cnn_pkg::*; ();

    // sender side
    logic  valid;
    word_t data;
    // final word of a frame
    logic  last;

    // receiver side
    logic  ready;

    // word moves when valid and ready are both high
    modport sender (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport receiver (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

//--- verilog/conv_layer.sv
`timescale 1ns/1ps

module conv_layer import cnn_pkg::*; (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  word_t [IN_ROWS-1:0][IN_COLS-1:0]   frame_i,
    input  logic                               frame_valid_i,
    output logic                               frame_ready_o,
    feature_stream_if.sender                   feat_o
);

    logic [1:0]                      state_q;
    word_t [IN_ROWS-1:0][IN_COLS-1:0] frame_q;
    logic [CONV_IDX_W-1:0]           out_idx_q;
    logic [TAP_ROW_W-1:0]            tap_row_q;
    logic [TAP_COL_W-1:0]            tap_col_q;
    word_t                           acc_q;
    logic [ROW_W-1:0]                frame_row;
    logic                            last_tap;
    logic                            last_out;
    word_t                           product;

    // kernel window starts at the output index
    assign frame_row = ROW_W'(out_idx_q) + ROW_W'(tap_row_q);
    // one tap per cycle
    assign product = fx_mul(KERNEL[tap_row_q][tap_col_q], frame_q[frame_row][tap_col_q]);

    assign last_tap = (tap_row_q == TAP_ROW_W'(K_ROWS - 1))
                   && (tap_col_q == TAP_COL_W'(IN_COLS - 1));
    assign last_out = (out_idx_q == CONV_IDX_W'(N_CONV - 1));

    // only accept a frame while idle
    assign frame_ready_o = (state_q == CONV_ST_IDLE);

    // word held in acc_q until taken
    assign feat_o.valid = (state_q == CONV_ST_SEND);
    assign feat_o.data  = acc_q;
    assign feat_o.last  = last_out;

    // control
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= CONV_ST_IDLE;
            out_idx_q <= '0;
            tap_row_q <= '0;
            tap_col_q <= '0;
        end else begin
            case (state_q)
                CONV_ST_IDLE: begin
                    if (frame_valid_i) begin
                        state_q   <= CONV_ST_MAC;
                        out_idx_q <= '0;
                        tap_row_q <= '0;
                        tap_col_q <= '0;
                    end
                end
                CONV_ST_MAC: begin
                    // walk the kernel row by row, columns inner
                    if (last_tap) begin
                        state_q   <= CONV_ST_BIAS;
                        tap_row_q <= '0;
                        tap_col_q <= '0;
                    end else if (tap_col_q == TAP_COL_W'(IN_COLS - 1)) begin
                        tap_col_q <= '0;
                        tap_row_q <= tap_row_q + 1'b1;
                    end else begin
                        tap_col_q <= tap_col_q + 1'b1;
                    end
                end
                CONV_ST_BIAS: begin
                    state_q <= CONV_ST_SEND;
                end
                CONV_ST_SEND: begin
                    // stall here on back-pressure
                    if (feat_o.ready) begin
                        if (last_out) begin
                            state_q <= CONV_ST_IDLE;
                        end else begin
                            out_idx_q <= out_idx_q + 1'b1;
                            state_q   <= CONV_ST_MAC;
                        end
                    end
                end
                default: begin
                    state_q <= CONV_ST_IDLE;
                end
            endcase
        end
    end

    // frame register and accumulator
    always_ff @(posedge clk_i) begin
        if (frame_ready_o && frame_valid_i) begin
            frame_q <= frame_i;
        end
        case (state_q)
            CONV_ST_IDLE: acc_q <= '0;
            // wraps at 16 bits
            CONV_ST_MAC:  acc_q <= acc_q + product;
            CONV_ST_BIAS: acc_q <= acc_q + CONV_BIAS;
            CONV_ST_SEND: begin
                if (feat_o.ready) begin
                    acc_q <= '0;
                end
            end
            default:      acc_q <= acc_q;
        endcase
    end

endmodule

//--- verilog/feature_fifo.sv
`timescale 1ns/1ps

module feature_fifo import cnn_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    feature_stream_if.receiver wr,
    feature_stream_if.sender   rd
);

    // payload and last flag side by side
    word_t            data_mem [FIFO_DEPTH];
    logic             last_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    // back-pressure upstream when full
    assign wr.ready = !full;

    // head entry read straight from the array
    assign rd.valid = !empty;
    assign rd.data  = data_mem[rd_ptr_q];
    assign rd.last  = last_mem[rd_ptr_q];

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= wr.data;
            last_mem[wr_ptr_q] <= wr.last;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- verilog/fc_stack.sv
`timescale 1ns/1ps

module fc_stack import cnn_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    feature_stream_if.receiver feat_i,
    output word_t [N_OUT-1:0]  result_o,
    output logic               result_valid_o,
    input  logic               result_yumi_i
);

    logic [2:0]            state_q;
    logic [CONV_IDX_W-1:0] in_idx_q;
    logic [HID_IDX_W-1:0]  hid_idx_q;
    word_t                 hid_acc_q [N_HIDDEN];
    word_t [N_OUT-1:0]     out_acc_q;
    word_t                 hid_prod [N_HIDDEN];
    word_t                 out_prod [N_OUT];
    logic                  take;
    logic                  last_hid;

    // closed from the last word until the result is taken
    assign feat_i.ready = (state_q == FC_ST_ACC);
    assign take         = feat_i.valid && feat_i.ready;
    assign last_hid     = (hid_idx_q == HID_IDX_W'(N_HIDDEN - 1));

    assign result_valid_o = (state_q == FC_ST_HOLD);
    assign result_o       = out_acc_q;

    // products for all neurons of a layer at once
    always_comb begin
        // input word against column in_idx of the hidden weights
        for (int n = 0; n < N_HIDDEN; n++) begin
            hid_prod[n] = fx_mul(HID_W[n][in_idx_q], feat_i.data);
        end
        // one hidden word fanned out to every output neuron
        for (int m = 0; m < N_OUT; m++) begin
            out_prod[m] = fx_mul(OUT_W[m][hid_idx_q], hid_acc_q[hid_idx_q]);
        end
    end

    // sequencer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= FC_ST_ACC;
            in_idx_q  <= '0;
            hid_idx_q <= '0;
        end else begin
            case (state_q)
                FC_ST_ACC: begin
                    if (take) begin
                        if (feat_i.last) begin
                            state_q  <= FC_ST_HBIAS;
                            in_idx_q <= '0;
                        end else begin
                            in_idx_q <= in_idx_q + 1'b1;
                        end
                    end
                end
                FC_ST_HBIAS: begin
                    state_q <= FC_ST_OUT;
                end
                FC_ST_OUT: begin
                    // one hidden word per cycle
                    if (last_hid) begin
                        state_q   <= FC_ST_OBIAS;
                        hid_idx_q <= '0;
                    end else begin
                        hid_idx_q <= hid_idx_q + 1'b1;
                    end
                end
                FC_ST_OBIAS: begin
                    state_q <= FC_ST_HOLD;
                end
                FC_ST_HOLD: begin
                    // result consumed in the yumi cycle
                    if (result_yumi_i) begin
                        state_q <= FC_ST_ACC;
                    end
                end
                default: begin
                    state_q <= FC_ST_ACC;
                end
            endcase
        end
    end

    // hidden accumulators, first word of a frame loads
    always_ff @(posedge clk_i) begin
        for (int n = 0; n < N_HIDDEN; n++) begin
            if (take) begin
                if (in_idx_q == '0) begin
                    hid_acc_q[n] <= hid_prod[n];
                end else begin
                    hid_acc_q[n] <= hid_acc_q[n] + hid_prod[n];
                end
            end else if (state_q == FC_ST_HBIAS) begin
                hid_acc_q[n] <= hid_acc_q[n] + HID_BIAS[n];
            end
        end
    end

    // output accumulators, held through FC_ST_HOLD
    always_ff @(posedge clk_i) begin
        for (int m = 0; m < N_OUT; m++) begin
            if (state_q == FC_ST_OUT) begin
                if (hid_idx_q == '0) begin
                    out_acc_q[m] <= out_prod[m];
                end else begin
                    out_acc_q[m] <= out_acc_q[m] + out_prod[m];
                end
            end else if (state_q == FC_ST_OBIAS) begin
                out_acc_q[m] <= out_acc_q[m] + OUT_BIAS[m];
            end
        end
    end

endmodule

//--- verilog/cnn_top.sv
`timescale 1ns/1ps

module cnn_top import cnn_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  word_t [IN_ROWS-1:0][IN_COLS-1:0] frame_i,
    input  logic                             frame_valid_i,
    output logic                             frame_ready_o,
    output word_t [N_OUT-1:0]                result_o,
    output logic                             result_valid_o,
    input  logic                             result_yumi_i
);

    // conv outputs into the buffer
    feature_stream_if conv_to_fifo ();
    // buffered features into the dense layers
    feature_stream_if fifo_to_fc ();

    // frame in, three conv words out
    conv_layer conv_layer_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .frame_i       (frame_i),
        .frame_valid_i (frame_valid_i),
        .frame_ready_o (frame_ready_o),
        .feat_o        (conv_to_fifo.sender)
    );

    // decouples conv timing from the dense layers
    feature_fifo feature_fifo_inst (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wr    (conv_to_fifo.receiver),
        .rd    (fifo_to_fc.sender)
    );

    // 3 to 2 to 4, result held until yumi
    fc_stack fc_stack_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .feat_i         (fifo_to_fc.receiver),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_yumi_i  (result_yumi_i)
    );

endmodule

//--- dv/cnn_properties.sv
`timescale 1ns/1ps

module cnn_properties import cnn_pkg::*; (
    input logic              clk_i,
    input logic              rst_i,
    input logic              frame_valid_i,
    input logic              frame_ready_i,
    input word_t [N_OUT-1:0] result_i,
    input logic              result_valid_i,
    input logic              result_yumi_i,
    input logic              wr_valid_i,
    input logic              wr_ready_i,
    input logic              wr_last_i,
    input logic              rd_valid_i,
    input logic              rd_ready_i
);

    logic push;
    logic pop;
    // fifo occupancy rebuilt from the two stream handshakes
    int   occ_q;
    // frame accepted, last conv word not yet handed over
    logic busy_q;

    assign push = wr_valid_i && wr_ready_i;
    assign pop  = rd_valid_i && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            occ_q  <= 0;
            busy_q <= 1'b0;
        end else begin
            if (push && !pop) begin
                occ_q <= occ_q + 1;
            end else if (pop && !push) begin
                occ_q <= occ_q - 1;
            end
            if (frame_valid_i && frame_ready_i) begin
                busy_q <= 1'b1;
            end else if (push && wr_last_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // held result must not move
    result_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_i && !result_yumi_i |=> $stable(result_i))
        else $error("result_o changed before yumi");

    result_held: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_i && !result_yumi_i |=> result_valid_i)
        else $error("result_valid_o dropped without yumi");

    no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
        push |-> occ_q < FIFO_DEPTH)
        else $error("word written into a full feature fifo");

    busy_not_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        busy_q |-> !frame_ready_i)
        else $error("frame_ready_o high while a frame is in the conv layer");

endmodule

bind cnn_top cnn_properties cnn_properties_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .frame_valid_i  (frame_valid_i),
    .frame_ready_i  (frame_ready_o),
    .result_i       (result_o),
    .result_valid_i (result_valid_o),
    .result_yumi_i  (result_yumi_i),
    .wr_valid_i     (conv_to_fifo.valid),
    .wr_ready_i     (conv_to_fifo.ready),
    .wr_last_i      (conv_to_fifo.last),
    .rd_valid_i     (fifo_to_fc.valid),
    .rd_ready_i     (fifo_to_fc.ready)
);

//--- dv/cnn_top_tb.sv
`timescale 1ns/1ps

module cnn_top_tb import cnn_pkg::*; ();

    typedef word_t [IN_ROWS-1:0][IN_COLS-1:0] frame_t;
    typedef word_t [N_OUT-1:0] result_t;

    localparam int N_DIR     = 5;
    localparam int N_RAND    = 3;
    localparam int N_VEC     = N_DIR + N_RAND;
    localparam int N_HAND    = 2;
    localparam int TIMEOUT   = 300;
    localparam int LONG_HOLD = 48;

    // directed frames, row major, values in quarters
    // zeros, all 1.0, two mixed-sign frames, one that overflows products
    localparam int DIR_FRAMES [N_DIR][IN_ROWS*IN_COLS] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{4, 4, 4, 4, 4, 4, 4, 4, 4, 4},
        '{6, -3, -10, 7, 2, -9, 13, -1, -5, 11},
        '{-1, 1, 3, -2, -7, 5, 9, -4, 1, -13},
        '{32767, -32767, 16384, 28672, -24576, 20480, 32767, 32767, -32768, 12345}
    };

    // worked out by hand, zero frame is the bias path alone
    localparam int HAND_EXP [N_HAND][N_OUT] = '{
        '{15, -37, 41, 68},
        '{11, -25, 29, 48}
    };

    logic        clk_i;
    logic        rst_i;
    frame_t      frame_i;
    logic        frame_valid_i;
    logic        frame_ready_o;
    result_t     result_o;
    logic        result_valid_o;
    logic        result_yumi_i;

    frame_t      tbl_frame [N_VEC];
    result_t     tbl_exp   [N_VEC];
    logic [31:0] lfsr_q;
    int          errors;
    int          timeouts;

    cnn_top cnn_top_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .frame_i        (frame_i),
        .frame_valid_i  (frame_valid_i),
        .frame_ready_o  (frame_ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_yumi_i  (result_yumi_i)
    );

    // 4 ns period
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // last resort if a loop below ever stops advancing
    initial begin
        #100000;
        $display("simulation watchdog expired before the test finished");
        $display("Errors found");
        $finish;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_lfsr_bit());
        end
        return v;
    endfunction

    // floor of the scaled product, low 16 bits kept
    function automatic word_t qmul(input word_t a, input word_t b);
        longint p;
        p = longint'(a) * longint'(b);
        p = p >>> FRAC_W;
        return word_t'(p[WORD_W-1:0]);
    endfunction

    // reference for conv, hidden and output layers; word_t sums wrap
    function automatic result_t model_result(input frame_t f);
        word_t   conv [N_CONV];
        word_t   hid  [N_HIDDEN];
        result_t res;
        for (int i = 0; i < N_CONV; i++) begin
            conv[i] = CONV_BIAS;
            for (int r = 0; r < K_ROWS; r++) begin
                for (int c = 0; c < IN_COLS; c++) begin
                    conv[i] = conv[i] + qmul(KERNEL[r][c], f[i+r][c]);
                end
            end
        end
        for (int n = 0; n < N_HIDDEN; n++) begin
            hid[n] = HID_BIAS[n];
            for (int i = 0; i < N_CONV; i++) begin
                hid[n] = hid[n] + qmul(HID_W[n][i], conv[i]);
            end
        end
        for (int m = 0; m < N_OUT; m++) begin
            res[m] = OUT_BIAS[m];
            for (int j = 0; j < N_HIDDEN; j++) begin
                res[m] = res[m] + qmul(OUT_W[m][j], hid[j]);
            end
        end
        return res;
    endfunction

    // directed rows first, then lfsr frames; hand values where known
    task automatic build_table();
        for (int k = 0; k < N_VEC; k++) begin
            for (int r = 0; r < IN_ROWS; r++) begin
                for (int c = 0; c < IN_COLS; c++) begin
                    if (k < N_DIR) begin
                        tbl_frame[k][r][c] = word_t'(DIR_FRAMES[k][r*IN_COLS+c]);
                    end else begin
                        tbl_frame[k][r][c] = word_t'(rand_bits(WORD_W));
                    end
                end
            end
            if (k < N_HAND) begin
                for (int m = 0; m < N_OUT; m++) begin
                    tbl_exp[k][m] = word_t'(HAND_EXP[k][m]);
                end
            end else begin
                tbl_exp[k] = model_result(tbl_frame[k]);
            end
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        for (int m = 0; m < N_OUT; m++) begin
            check_word($sformatf("%s[%0d]", name, m), exp[m], act[m]);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_frame(input frame_t f);
        int waited;
        frame_i       = f;
        frame_valid_i = 1'b1;
        waited        = 0;
        while (frame_ready_o !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            timeouts++;
            $display("timeout: frame_ready_o stayed low, frame not accepted");
        end
        // handshake on the rising edge in between
        @(negedge clk_i);
        frame_valid_i = 1'b0;
    endtask

    // result checked every cycle it is held, then yumied
    task automatic take_result(input result_t exp, input int delay);
        int waited;
        waited = 0;
        while (result_valid_o !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            timeouts++;
            $display("timeout: result_valid_o never rose for an expected result");
            return;
        end
        check_result("result_o", exp, result_o);
        repeat (delay) begin
            @(negedge clk_i);
            check_bit("result_valid_o", 1'b1, result_valid_o);
            check_result("result_o", exp, result_o);
        end
        result_yumi_i = 1'b1;
        @(negedge clk_i);
        result_yumi_i = 1'b0;
    endtask

    initial begin
        errors        = 0;
        timeouts      = 0;
        lfsr_q        = 32'h9a36;
        rst_i         = 1'b1;
        frame_i       = '0;
        frame_valid_i = 1'b0;
        result_yumi_i = 1'b0;
        build_table();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        // idle right out of reset
        check_bit("frame_ready_o", 1'b1, frame_ready_o);
        check_bit("result_valid_o", 1'b0, result_valid_o);
        // whole table back to back, yumi delayed 0 to 7 cycles
        fork
            begin
                for (int i = 0; i < N_VEC; i++) begin
                    send_frame(tbl_frame[i]);
                end
            end
            begin
                for (int i = 0; i < N_VEC; i++) begin
                    take_result(tbl_exp[i], rand_bits(3));
                end
            end
        join
        // first result held long while two more frames queue behind it
        // fifo fills and the conv layer stalls on ready
        fork
            begin
                for (int i = 2; i < 5; i++) begin
                    send_frame(tbl_frame[i]);
                end
            end
            begin
                take_result(tbl_exp[2], LONG_HOLD);
                take_result(tbl_exp[3], rand_bits(3));
                take_result(tbl_exp[4], rand_bits(3));
            end
        join
        // no extra result may show up
        repeat (20) begin
            @(negedge clk_i);
            check_bit("result_valid_o", 1'b0, result_valid_o);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/cnn_pkg.sv
verilog/feature_stream_if.sv
verilog/conv_layer.sv
verilog/feature_fifo.sv
verilog/fc_stack.sv
verilog/cnn_top.sv
dv/cnn_properties.sv
dv/cnn_top_tb.sv

//--- Makefile
# Verilator flow for the CNN pipeline testbench

TOP       ?= cnn_top_tb
FILELIST  ?= src.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FAIL_MSG  ?= Errors found

VFLAGS ?= --timing --assert --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@status=0; ./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || grep -q "%Error" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
